// File: common/procPkg.sv
/*
 * Shared types and constants for the 16-bit pipelined core.
 * Every stage imports this package for word widths, opcode
 * values and memory depths. The testbench uses the same names
 * to encode programs and run its reference model.
 */
`default_nettype none
package procPkg;

   // Widths that carry a meaning
   typedef logic [15:0] dataT;
   typedef logic [15:0] instrT;
   typedef logic [7:0]  pcT;
   typedef logic [2:0]  regAddrT;
   typedef logic [3:0]  opcodeT;

   // Opcode field values, bits 15 to 12
   localparam opcodeT OP_NOP  = 4'd0;
   localparam opcodeT OP_ADD  = 4'd1;
   localparam opcodeT OP_SUB  = 4'd2;
   localparam opcodeT OP_AND  = 4'd3;
   localparam opcodeT OP_XOR  = 4'd4;
   localparam opcodeT OP_ADDI = 4'd5;
   localparam opcodeT OP_LI   = 4'd6;
   localparam opcodeT OP_LD   = 4'd7;
   localparam opcodeT OP_ST   = 4'd8;
   localparam opcodeT OP_BEQZ = 4'd9;
   localparam opcodeT OP_BNEZ = 4'd10;
   localparam opcodeT OP_J    = 4'd11;
   // 12 to 14 are undefined and trap
   localparam opcodeT OP_HALT = 4'd15;

   // ALU function carried from decode to execute
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_PASSB
   } aluOpT;

   // Depth of instruction and data memory, in words
   localparam int MEM_WORDS = 256;
   localparam int NUM_REGS  = 8;

endpackage
`default_nettype wire

// File: common/stageIfs.sv
/*
 * Pipeline register bundles between stages.
 * decExIf carries the decoded instruction into execute, and
 * exMemIf carries the execute result into the memory stage.
 * The hz modport lets decode see the memory-stage writer.
 */
`default_nettype none
interface decExIf;
   import procPkg::*;

   logic  valid;
   aluOpT aluOp;
   dataT  opA;
   dataT  opB;
   dataT  storeData;
   regAddrT dst;
   logic  wrEn;
   logic  memRd;
   logic  memWr;
   logic  isBeqz;
   logic  isBnez;
   logic  isJump;
   pcT    target;
   logic  halt;
   logic  err;

   modport dec (output valid, aluOp, opA, opB, storeData, dst, wrEn, memRd, memWr,
                isBeqz, isBnez, isJump, target, halt, err);
   modport ex (input valid, aluOp, opA, opB, storeData, dst, wrEn, memRd, memWr,
               isBeqz, isBnez, isJump, target, halt, err);
endinterface

interface exMemIf;
   import procPkg::*;

   logic    valid;
   dataT    result;
   dataT    storeData;
   regAddrT dst;
   logic    wrEn;
   logic    memRd;
   logic    memWr;
   logic    halt;
   logic    err;

   modport ex (output valid, result, storeData, dst, wrEn, memRd, memWr, halt, err);
   modport mem (input valid, result, storeData, dst, wrEn, memRd, memWr, halt, err);
   modport hz (input valid, dst, wrEn);
endinterface
`default_nettype wire

// File: hw/fetch/fetch.sv
/*
 * Fetch stage. Holds the PC and the instruction memory, which is
 * loaded through the program port while the core is in reset.
 * The fetched word and its PC go into the fetch/decode register.
 * Stall and halt freeze the stage; a redirect loads a bubble.
 */
`default_nettype none
module fetch (
   input  wire                  clk,
   input  wire                  rstN,
   input  wire                  progWrEn,
   input  wire procPkg::pcT     progAddr,
   input  wire procPkg::instrT  progData,
   input  wire                  stall,
   input  wire                  haltReq,
   input  wire                  redirect,
   input  wire procPkg::pcT     redirectPc,
   output logic                 fdValid,
   output procPkg::instrT       fdInstr,
   output procPkg::pcT          fdPc
);
   import procPkg::*;

   instrT imem [MEM_WORDS];
   pcT    pc;
   logic  advance;

   assign advance = !stall && !haltReq;

   // Program load port
   always_ff @(posedge clk) begin
      if (progWrEn) begin
         imem[progAddr] <= progData;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc      <= '0;
         fdValid <= 1'b0;
      end else if (redirect) begin
         pc      <= redirectPc;
         fdValid <= 1'b0;
      end else if (advance) begin
         pc      <= pc + pcT'(1);
         fdValid <= 1'b1;
      end
   end

   // Fetched word and its address
   always_ff @(posedge clk) begin
      if (!redirect && advance) begin
         fdInstr <= imem[pc];
         fdPc    <= pc;
      end
   end

   // Loading is only legal with the core held in reset
   assert property (@(posedge clk) rstN |-> !progWrEn);

endmodule
`default_nettype wire

// File: hw/decode/regFile.sv
/*
 * Eight-entry register file with two read ports and one write port.
 * r0 always reads as zero. A write in the same cycle as a read of
 * that register is bypassed to the read port.
 */
`default_nettype none
module regFile (
   input  wire                  clk,
   input  wire                  rstN,
   input  wire procPkg::regAddrT rdAddrA,
   input  wire procPkg::regAddrT rdAddrB,
   output procPkg::dataT        rdDataA,
   output procPkg::dataT        rdDataB,
   input  wire                  wrEn,
   input  wire procPkg::regAddrT wrAddr,
   input  wire procPkg::dataT    wrData
);
   import procPkg::*;

   dataT regs [NUM_REGS];
   logic wrOk;

   assign wrOk = wrEn && (wrAddr != '0);

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         regs <= '{default: '0};
      end else if (wrOk) begin
         regs[wrAddr] <= wrData;
      end
   end

   assign rdDataA = (wrOk && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
   assign rdDataB = (wrOk && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule
`default_nettype wire

// File: hw/decode/decode.sv
/*
 * Decode stage. Splits the instruction into fields, reads the
 * register file and builds the operands and branch target.
 * Stalls on a read-after-write hit against execute or memory,
 * and turns HALT or an undefined opcode into a halt request.
 */
`default_nettype none
module decode (
   input  wire                   clk,
   input  wire                   rstN,
   input  wire                   fdValid,
   input  wire procPkg::instrT   fdInstr,
   input  wire procPkg::pcT      fdPc,
   input  wire                   redirect,
   input  wire                   wbValid,
   input  wire procPkg::regAddrT wbDst,
   input  wire procPkg::dataT    wbData,
   decExIf.dec                   decEx,
   exMemIf.hz                    exMemHz,
   output logic                  stall,
   output logic                  haltReq
);
   import procPkg::*;

   opcodeT  op;
   regAddrT rd, rs, rt, rdAddrB;
   dataT    rsData, rbData, imm6, imm9, opBN;
   pcT      brOff;
   aluOpT   aluOpN;
   logic    usesRs, usesRb, writesRd, memRdN, memWrN, beqzN, bnezN, jumpN;
   logic    isHaltOp, isUndef, rsHit, rbHit, haltSeen, issue;

   assign op      = fdInstr[15:12];
   assign rd      = fdInstr[11:9];
   assign rs      = fdInstr[8:6];
   assign rt      = fdInstr[5:3];
   // ST reads its data from the rd field
   assign rdAddrB = (op == OP_ST) ? rd : rt;
   assign imm6    = {{10{fdInstr[5]}}, fdInstr[5:0]};
   assign imm9    = {{7{fdInstr[8]}}, fdInstr[8:0]};
   assign brOff   = jumpN ? fdInstr[7:0] : {{2{fdInstr[5]}}, fdInstr[5:0]};

   regFile rf0 (.clk(clk), .rstN(rstN), .rdAddrA(rs), .rdAddrB(rdAddrB),
                .rdDataA(rsData), .rdDataB(rbData),
                .wrEn(wbValid), .wrAddr(wbDst), .wrData(wbData));

   always_comb begin
      aluOpN = ALU_ADD;
      opBN = rbData;
      {usesRs, usesRb, writesRd, memRdN, memWrN} = '0;
      {beqzN, bnezN, jumpN, isHaltOp, isUndef} = '0;
      case (op)
         OP_NOP: ;
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            aluOpN = (op == OP_SUB) ? ALU_SUB : (op == OP_AND) ? ALU_AND :
                     (op == OP_XOR) ? ALU_XOR : ALU_ADD;
            {usesRs, usesRb, writesRd} = 3'b111;
         end
         OP_ADDI: begin usesRs = 1'b1; writesRd = 1'b1; opBN = imm6; end
         OP_LI:   begin aluOpN = ALU_PASSB; writesRd = 1'b1; opBN = imm9; end
         OP_LD:   begin usesRs = 1'b1; writesRd = 1'b1; memRdN = 1'b1; opBN = imm6; end
         OP_ST:   begin usesRs = 1'b1; usesRb = 1'b1; memWrN = 1'b1; opBN = imm6; end
         OP_BEQZ: begin usesRs = 1'b1; beqzN = 1'b1; end
         OP_BNEZ: begin usesRs = 1'b1; bnezN = 1'b1; end
         OP_J:    jumpN = 1'b1;
         OP_HALT: isHaltOp = 1'b1;
         default: begin isHaltOp = 1'b1; isUndef = 1'b1; end
      endcase
   end

   // Writers still in execute or memory; writeback is covered by the bypass
   assign rsHit = usesRs && ((decEx.valid && decEx.wrEn && decEx.dst == rs) ||
                             (exMemHz.valid && exMemHz.wrEn && exMemHz.dst == rs));
   assign rbHit = usesRb && ((decEx.valid && decEx.wrEn && decEx.dst == rdAddrB) ||
                             (exMemHz.valid && exMemHz.wrEn && exMemHz.dst == rdAddrB));
   assign stall   = fdValid && (rsHit || rbHit) && !redirect;
   assign haltReq = haltSeen || (fdValid && isHaltOp && !redirect);
   assign issue   = fdValid && !stall && !redirect && !haltSeen;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         haltSeen <= 1'b0;
         {decEx.valid, decEx.wrEn, decEx.memRd, decEx.memWr} <= '0;
         {decEx.isBeqz, decEx.isBnez, decEx.isJump, decEx.halt, decEx.err} <= '0;
      end else begin
         haltSeen     <= haltReq;
         decEx.valid  <= issue;
         decEx.wrEn   <= issue && writesRd && (rd != '0);
         decEx.memRd  <= issue && memRdN;
         decEx.memWr  <= issue && memWrN;
         decEx.isBeqz <= issue && beqzN;
         decEx.isBnez <= issue && bnezN;
         decEx.isJump <= issue && jumpN;
         decEx.halt   <= issue && isHaltOp;
         decEx.err    <= issue && isUndef;
      end
   end

   always_ff @(posedge clk) begin
      decEx.aluOp     <= aluOpN;
      decEx.opA       <= rsData;
      decEx.opB       <= opBN;
      decEx.storeData <= rbData;
      decEx.dst       <= rd;
      decEx.target    <= fdPc + pcT'(1) + brOff;
   end

   // Both slots behind a taken branch leave decode as bubbles
   assert property (@(posedge clk) disable iff (!rstN)
      ($past(redirect) || $past(redirect, 2)) |-> !decEx.valid);

endmodule
`default_nettype wire

// File: hw/execute.sv
/*
 * Execute stage. Runs the ALU on the decoded operands, which gives
 * either a register result or a data memory address. Branches and
 * jumps resolve here and send a one-cycle redirect to the front.
 * The result bundle is registered into the execute/memory register.
 */
`default_nettype none
module execute (
   input  wire               clk,
   input  wire               rstN,
   decExIf.ex                decEx,
   exMemIf.ex                exMem,
   output logic              redirect,
   output procPkg::pcT       redirectPc
);
   import procPkg::*;

   dataT aluRes;
   logic opAZero;
   logic taken;

   always_comb begin
      case (decEx.aluOp)
         ALU_ADD:   aluRes = decEx.opA + decEx.opB;
         ALU_SUB:   aluRes = decEx.opA - decEx.opB;
         ALU_AND:   aluRes = decEx.opA & decEx.opB;
         ALU_XOR:   aluRes = decEx.opA ^ decEx.opB;
         ALU_PASSB: aluRes = decEx.opB;
         default:   aluRes = decEx.opB;
      endcase
   end

   // Conditional branches test rs only
   assign opAZero = (decEx.opA == '0);
   assign taken   = decEx.isJump || (decEx.isBeqz && opAZero) ||
                    (decEx.isBnez && !opAZero);

   assign redirect   = decEx.valid && taken;
   assign redirectPc = decEx.target;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         exMem.valid <= 1'b0;
         exMem.wrEn  <= 1'b0;
         exMem.memRd <= 1'b0;
         exMem.memWr <= 1'b0;
         exMem.halt  <= 1'b0;
         exMem.err   <= 1'b0;
      end else begin
         exMem.valid <= decEx.valid;
         exMem.wrEn  <= decEx.valid && decEx.wrEn;
         exMem.memRd <= decEx.valid && decEx.memRd;
         exMem.memWr <= decEx.valid && decEx.memWr;
         exMem.halt  <= decEx.valid && decEx.halt;
         exMem.err   <= decEx.valid && decEx.err;
      end
   end

   always_ff @(posedge clk) begin
      exMem.result    <= aluRes;
      exMem.storeData <= decEx.storeData;
      exMem.dst       <= decEx.dst;
   end

   // Decode marks exactly one branch kind on a valid instruction
   assert property (@(posedge clk) disable iff (!rstN)
      redirect |-> decEx.valid && $onehot({decEx.isBeqz, decEx.isBnez, decEx.isJump}));

endmodule
`default_nettype wire

// File: hw/memStage.sv
/*
 * Memory stage. Holds the data memory, stores on memWr and picks
 * the loaded word or the ALU result for writeback. The writeback
 * register drives the register file and the retire trace.
 * halted and err are sticky once a halt flag arrives.
 */
`default_nettype none
module memStage (
   input  wire                clk,
   input  wire                rstN,
   exMemIf.mem                exMem,
   output logic               wbValid,
   output procPkg::regAddrT   wbDst,
   output procPkg::dataT      wbData,
   output logic               halted,
   output logic               err
);
   import procPkg::*;

   dataT dmem [MEM_WORDS];
   pcT   addr;

   // Word address is the low byte of the ALU result
   assign addr = exMem.result[7:0];

   always_ff @(posedge clk) begin
      if (exMem.valid && exMem.memWr) begin
         dmem[addr] <= exMem.storeData;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         wbValid <= 1'b0;
         halted  <= 1'b0;
         err     <= 1'b0;
      end else begin
         wbValid <= exMem.valid && exMem.wrEn;
         if (exMem.valid && exMem.halt) begin
            halted <= 1'b1;
            err    <= exMem.err;
         end
      end
   end

   always_ff @(posedge clk) begin
      wbDst  <= exMem.dst;
      wbData <= exMem.memRd ? dmem[addr] : exMem.result;
   end

   assert property (@(posedge clk) disable iff (!rstN) !(exMem.memRd && exMem.memWr));

endmodule
`default_nettype wire

// File: hw/proc.sv
/*
 * Top level of the five-stage core. Connects fetch, decode,
 * execute and the memory stage through the stage bundles.
 * Load a program with progWrEn while rstN is low, then release.
 * Every register write shows up on the retire ports.
 */
`default_nettype none
module proc (
   input  wire                   clk,
   input  wire                   rstN,
   input  wire                   progWrEn,
   input  wire procPkg::pcT      progAddr,
   input  wire procPkg::instrT   progData,
   output logic                  halted,
   output logic                  err,
   output logic                  retireValid,
   output procPkg::regAddrT      retireDst,
   output procPkg::dataT         retireData
);
   import procPkg::*;

   // Fetch to decode
   logic    fdValid;
   instrT   fdInstr;
   pcT      fdPc;

   // Back-edge control
   logic    stall;
   logic    haltReq;
   logic    redirect;
   pcT      redirectPc;

   // Writeback
   logic    wbValid;
   regAddrT wbDst;
   dataT    wbData;

   decExIf decEx ();
   exMemIf exMem ();

   fetch fetch0 (.clk(clk), .rstN(rstN),
                 .progWrEn(progWrEn), .progAddr(progAddr), .progData(progData),
                 .stall(stall), .haltReq(haltReq),
                 .redirect(redirect), .redirectPc(redirectPc),
                 .fdValid(fdValid), .fdInstr(fdInstr), .fdPc(fdPc));

   decode decode0 (.clk(clk), .rstN(rstN),
                   .fdValid(fdValid), .fdInstr(fdInstr), .fdPc(fdPc),
                   .redirect(redirect),
                   .wbValid(wbValid), .wbDst(wbDst), .wbData(wbData),
                   .decEx(decEx), .exMemHz(exMem),
                   .stall(stall), .haltReq(haltReq));

   execute execute0 (.clk(clk), .rstN(rstN), .decEx(decEx), .exMem(exMem),
                     .redirect(redirect), .redirectPc(redirectPc));

   memStage memory0 (.clk(clk), .rstN(rstN), .exMem(exMem),
                     .wbValid(wbValid), .wbDst(wbDst), .wbData(wbData),
                     .halted(halted), .err(err));

   assign retireValid = wbValid;
   assign retireDst   = wbDst;
   assign retireData  = wbData;

endmodule
`default_nettype wire

// File: verification/procTb.sv
/*
 * Self-checking testbench for the pipelined core.
 * Loads each program into instruction memory during reset, runs an
 * ISA model over the same words to get the expected register writes,
 * then checks the retire trace and the halt/err status against it.
 */
`default_nettype none
module procTb;
   import procPkg::*;

   localparam int LOAD_WORDS = 32;
   localparam int MAX_EXP    = 64;

   logic    clk;
   logic    rstN;
   logic    progWrEn;
   pcT      progAddr;
   instrT   progData;
   logic    halted;
   logic    err;
   logic    retireValid;
   regAddrT retireDst;
   dataT    retireData;

   instrT   prog [LOAD_WORDS];
   regAddrT expDst [MAX_EXP];
   dataT    expData [MAX_EXP];
   int      expBeh [MAX_EXP];
   int      expCount;
   int      expHead;
   int      executed;
   logic    expErr;
   int      seed = 50;
   // Error counts per behavior, 1 to 6
   int      errs [1:6];
   int      haltBeh;
   logic    timedOut;
   int      testsRun;
   int      testsFailed;

   proc dut0 (.clk(clk), .rstN(rstN), .progWrEn(progWrEn), .progAddr(progAddr),
              .progData(progData), .halted(halted), .err(err),
              .retireValid(retireValid), .retireDst(retireDst), .retireData(retireData));

   always #4 clk = ~clk;

   // Status stays quiet while reset is held
   assert property (@(posedge clk) !rstN |-> !halted && !err && !retireValid)
      else begin
         errs[1]++;
         $display("Status output active during reset at time %0t", $time);
      end

   assert property (@(posedge clk) disable iff (!rstN) halted |-> !retireValid)
      else begin
         errs[haltBeh]++;
         $display("Retire seen after halt at time %0t", $time);
      end

   assert property (@(posedge clk) disable iff (!rstN) err |-> halted)
      else begin
         errs[haltBeh]++;
         $display("err high without halted at time %0t", $time);
      end

   // err rises together with halted, and only for a trap
   assert property (@(posedge clk) disable iff (!rstN) halted |-> err == expErr)
      else begin
         errs[haltBeh]++;
         $display("Error: time %0t err got %b expected %b", $time, err, expErr);
      end

   // Retire trace against the model queue, sampled mid-cycle
   always @(negedge clk) begin
      if (rstN && retireValid) begin
         if (expHead >= expCount) begin
            errs[haltBeh]++;
            $display("Unexpected retire of r%0d at time %0t", retireDst, $time);
         end else begin
            assert (retireDst == expDst[expHead])
               else begin
                  errs[expBeh[expHead]]++;
                  $display("Error: time %0t retireDst got %0d expected %0d",
                           $time, retireDst, expDst[expHead]);
               end
            assert (retireData == expData[expHead])
               else begin
                  errs[expBeh[expHead]]++;
                  $display("Error: time %0t retireData got %h expected %h",
                           $time, retireData, expData[expHead]);
               end
            expHead++;
         end
      end
   end

   function automatic instrT rType(opcodeT op, regAddrT rd, regAddrT rs, regAddrT rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic instrT iType(opcodeT op, regAddrT rd, regAddrT rs, logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   function automatic instrT liWord(regAddrT rd, logic [8:0] imm);
      return {OP_LI, rd, imm};
   endfunction

   function automatic instrT jumpWord(logic [11:0] off);
      return {OP_J, off};
   endfunction

   task automatic buildProgram1();
      logic [8:0] v1;
      logic [8:0] v2;
      begin
         v1 = 9'($random(seed));
         v2 = 9'($random(seed));
         foreach (prog[i]) prog[i] = '0;
         prog[0]  = liWord(3'd1, v1);
         prog[1]  = liWord(3'd2, v2);
         // Back-to-back dependent chain
         prog[2]  = rType(OP_ADD, 3'd3, 3'd1, 3'd2);
         prog[3]  = rType(OP_SUB, 3'd4, 3'd3, 3'd1);
         prog[4]  = rType(OP_AND, 3'd5, 3'd4, 3'd2);
         prog[5]  = rType(OP_XOR, 3'd6, 3'd5, 3'd3);
         prog[6]  = iType(OP_ADDI, 3'd7, 3'd6, 6'h3D);
         prog[7]  = liWord(3'd1, 9'd20);
         prog[8]  = iType(OP_ST, 3'd7, 3'd1, 6'd2);
         prog[9]  = iType(OP_ADDI, 3'd2, 3'd0, 6'd5);
         // Load-use pair
         prog[10] = iType(OP_LD, 3'd3, 3'd1, 6'd2);
         prog[11] = rType(OP_ADD, 3'd4, 3'd3, 3'd3);
         prog[12] = iType(OP_BEQZ, 3'd0, 3'd0, 6'd1);
         prog[13] = liWord(3'd5, 9'd1);
         prog[14] = iType(OP_BNEZ, 3'd0, 3'd0, 6'd5);
         prog[15] = iType(OP_BEQZ, 3'd0, 3'd2, 6'd3);
         prog[16] = iType(OP_BNEZ, 3'd0, 3'd2, 6'd1);
         prog[17] = liWord(3'd6, 9'd2);
         // Both slots behind the jump hold register writes
         prog[18] = jumpWord(12'd2);
         prog[19] = liWord(3'd7, 9'd3);
         prog[20] = liWord(3'd5, 9'd4);
         prog[21] = '0;
         prog[22] = iType(OP_ADDI, 3'd1, 3'd1, 6'd1);
         prog[23] = {OP_HALT, 12'd0};
      end
   endtask

   task automatic buildProgram2();
      begin
         foreach (prog[i]) prog[i] = '0;
         prog[0] = liWord(3'd1, 9'd7);
         prog[1] = iType(OP_ADDI, 3'd2, 3'd1, 6'd3);
         prog[2] = rType(OP_XOR, 3'd3, 3'd2, 3'd1);
         prog[3] = {4'd12, 12'd0};
         prog[4] = iType(OP_ADDI, 3'd4, 3'd0, 6'd1);
      end
   endtask

   // Sequential ISA model producing the expected write trace
   task automatic runModel();
      dataT    regs [8];
      dataT    dmem [int];
      pcT      pc;
      pcT      nextPc;
      instrT   w;
      opcodeT  op;
      regAddrT rd;
      regAddrT rs;
      regAddrT rt;
      dataT    imm6;
      dataT    joff;
      dataT    wv;
      logic    wr;
      logic    done;
      logic    branched;
      begin
         foreach (regs[i]) regs[i] = '0;
         pc = '0;
         done = 1'b0;
         branched = 1'b0;
         expCount = 0;
         expErr = 1'b0;
         executed = 0;
         while (!done && executed < 200) begin
            w = (int'(pc) < LOAD_WORDS) ? prog[pc[4:0]] : '0;
            op = w[15:12];
            rd = w[11:9];
            rs = w[8:6];
            rt = w[5:3];
            imm6 = {{10{w[5]}}, w[5:0]};
            joff = {{4{w[11]}}, w[11:0]};
            nextPc = pc + 8'd1;
            wr = 1'b0;
            wv = '0;
            executed++;
            case (op)
               OP_NOP: ;
               OP_ADD:  begin wv = regs[rs] + regs[rt]; wr = 1'b1; end
               OP_SUB:  begin wv = regs[rs] - regs[rt]; wr = 1'b1; end
               OP_AND:  begin wv = regs[rs] & regs[rt]; wr = 1'b1; end
               OP_XOR:  begin wv = regs[rs] ^ regs[rt]; wr = 1'b1; end
               OP_ADDI: begin wv = regs[rs] + imm6; wr = 1'b1; end
               OP_LI:   begin wv = {{7{w[8]}}, w[8:0]}; wr = 1'b1; end
               OP_LD: begin
                  wv = dmem[int'(8'(regs[rs] + imm6))];
                  wr = 1'b1;
               end
               OP_ST:   dmem[int'(8'(regs[rs] + imm6))] = regs[rd];
               OP_BEQZ: if (regs[rs] == '0) nextPc = pc + 8'd1 + imm6[7:0];
               OP_BNEZ: if (regs[rs] != '0) nextPc = pc + 8'd1 + imm6[7:0];
               OP_J:    nextPc = pc + 8'd1 + joff[7:0];
               OP_HALT: done = 1'b1;
               default: begin done = 1'b1; expErr = 1'b1; end
            endcase
            if (wr && rd != '0) begin
               regs[rd] = wv;
               expDst[expCount] = rd;
               expData[expCount] = wv;
               // Behavior that a wrong value of this write belongs to
               if (haltBeh == 6) begin
                  expBeh[expCount] = 6;
               end else if (op == OP_LD) begin
                  expBeh[expCount] = 3;
               end else if (branched) begin
                  expBeh[expCount] = 4;
               end else begin
                  expBeh[expCount] = 2;
               end
               expCount++;
            end
            if (op == OP_BEQZ || op == OP_BNEZ || op == OP_J) begin
               branched = 1'b1;
            end
            pc = nextPc;
         end
      end
   endtask

   task automatic runProgram(input int progId);
      int cycles;
      int limit;
      begin
         haltBeh = (progId == 2) ? 6 : 5;
         runModel();
         expHead = 0;
         rstN = 1'b0;
         repeat (8) @(negedge clk);
         for (int i = 0; i < LOAD_WORDS; i++) begin
            progWrEn = 1'b1;
            progAddr = pcT'(i);
            progData = prog[i];
            @(negedge clk);
         end
         progWrEn = 1'b0;
         @(negedge clk);
         rstN = 1'b1;
         // Nothing can retire in the first cycles after release
         repeat (2) begin
            @(negedge clk);
            if (halted || err || retireValid) begin
               errs[1]++;
               $display("Status active right after reset at time %0t", $time);
            end
         end
         limit = 3 * executed + 50;
         cycles = 0;
         while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
         end
         if (!halted) begin
            timedOut = 1'b1;
            errs[haltBeh]++;
            $display("Timeout: program %0d did not halt within %0d cycles", progId, limit);
         end else begin
            repeat (6) @(negedge clk);
            if (expHead != expCount) begin
               errs[haltBeh]++;
               $display("Program %0d halted with %0d of %0d writes retired",
                        progId, expHead, expCount);
            end
         end
      end
   endtask

   task automatic reportTest(input string name, input int errCount);
      begin
         testsRun++;
         if (errCount == 0) begin
            $display("[ok]   %s", name);
         end else begin
            testsFailed++;
            $display("[bad]  %s (%0d errors)", name, errCount);
         end
      end
   endtask

   initial begin
      int total;
      clk = 1'b0;
      rstN = 1'b0;
      progWrEn = 1'b0;
      progAddr = '0;
      progData = '0;
      expCount = 0;
      expHead = 0;
      expErr = 1'b0;
      haltBeh = 5;
      timedOut = 1'b0;
      total = 0;
      foreach (errs[i]) errs[i] = 0;
      {testsRun, testsFailed} = '0;

      buildProgram1();
      runProgram(1);
      reportTest("ALU, ADDI and LI results in program order", errs[2]);
      reportTest("store followed by a load of the same address", errs[3]);
      reportTest("branches, jump and flushed slots", errs[4]);
      reportTest("program 1 clean halt", errs[5]);

      if (!timedOut) begin
         buildProgram2();
         runProgram(2);
         reportTest("program 2 error trap", errs[6]);
      end
      reportTest("status quiet during and after reset", errs[1]);

      foreach (errs[i]) total += errs[i];
      $display("%0d tests, %0d failed, %0d check errors", testsRun, testsFailed, total);
      if (testsFailed == 0 && !timedOut) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule
`default_nettype wire

// File: proc.f
common/procPkg.sv
common/stageIfs.sv
hw/fetch/fetch.sv
hw/decode/regFile.sv
hw/decode/decode.sv
hw/execute.sv
hw/memStage.sv
hw/proc.sv
verification/procTb.sv

// File: Makefile
# Verilator build and run for the pipelined core

VERILATOR ?= verilator
TOP       ?= procTb
RTL_TOP   ?= proc
FILELIST  ?= proc.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "*** TEST PASSED ***"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
